//--- Bender.yml
package:
  name: rr_record

sources:
  - rr_pkg.sv
  - ram_fifo_ft.sv
  - rr_channel_logger.sv
  - rr_logb_packer.sv
  - rr_packed2writeback_bus.sv
  - rr_record_top.sv
  - target: test
    files:
      - rr_record_properties.sv
      - tb_rr_record.sv

//--- project.f
rr_pkg.sv
ram_fifo_ft.sv
rr_channel_logger.sv
rr_logb_packer.sv
rr_packed2writeback_bus.sv
rr_record_top.sv
rr_record_properties.sv
tb_rr_record.sv

//--- ram_fifo_ft.sv
`timescale 1ns/1ps
`default_nettype none

// fall-through fifo, head word lives in a register in front of the ram
module ram_fifo_ft #(
   parameter int width = 8,
   parameter int ptr_width = 4,
   parameter int watermark = 12
) (
   input wire logic clk,
   input wire logic rstn,
   input wire logic push,
   input wire logic [width-1:0] push_data,
   input wire logic pop,
   output logic [width-1:0] pop_data,
   output logic valid,
   output logic wmark,
   output logic oflow,
   output logic empty
);

   localparam int depth = 2 ** ptr_width;

   logic [width-1:0] mem [depth];
   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   // total occupancy, head register included
   logic [ptr_width:0] count;
   // words still waiting in the ram
   logic [ptr_width:0] mem_cnt;
   logic mem_avail;
   logic full;
   logic push_acc;
   logic pop_acc;
   logic load_out;
   logic bypass;

   assign full = (count == (ptr_width + 1)'(depth));
   assign push_acc = push && !full;
   assign pop_acc = pop && valid;
   assign mem_cnt = count - (ptr_width + 1)'(valid);
   assign mem_avail = (mem_cnt != '0);
   // head register is free now or frees on this edge
   assign load_out = !valid || pop_acc;
   // empty ram, new word goes straight to the head
   assign bypass = push_acc && load_out && !mem_avail;

   assign wmark = (int'(count) >= watermark);
   assign empty = (count == '0);

   // ram write port
   always_ff @(posedge clk) begin
      if (push_acc && !bypass) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // head data, refilled from ram first to keep order
   always_ff @(posedge clk) begin
      if (load_out) begin
         if (mem_avail) begin
            pop_data <= mem[rd_ptr];
         end else if (bypass) begin
            pop_data <= push_data;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         valid <= 1'b0;
         oflow <= 1'b0;
      end else begin
         if (push_acc && !bypass) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (load_out && mem_avail) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (load_out) begin
            valid <= mem_avail || bypass;
         end
         count <= count + (ptr_width + 1)'(push_acc) - (ptr_width + 1)'(pop_acc);
         // sticky, a dropped word is never recovered
         if (push && full) begin
            oflow <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- rr_channel_logger.sv
`timescale 1ns/1ps
`default_nettype none

// sits on one valid/ready channel between source and sink
module rr_channel_logger import rr_pkg::*; (
   input wire logic clk,
   input wire logic rstn,
   input wire logic src_valid,
   input wire ch_data_t src_data,
   output logic src_ready,
   output logic sink_valid,
   input wire logic sink_ready,
   input wire logic almful,
   output logic logb_valid,
   output ch_data_t logb_data,
   output logic loge_valid
);

   logger_state_t state;
   logger_state_t state_nxt;
   logic hs;
   logic begin_seen;

   // blocked hides the source, nothing else touches the channel
   assign sink_valid = (state != blocked) && src_valid;
   assign src_ready = (state != blocked) && sink_ready;
   assign hs = sink_valid && sink_ready;
   // first cycle of a new transaction
   assign begin_seen = (state == idle) && src_valid;

   always_comb begin
      state_nxt = state;
      case (state)
         idle: begin
            // a one-cycle transaction stays out of pending
            if (src_valid && !hs) begin
               state_nxt = pending;
            end else if (almful) begin
               state_nxt = blocked;
            end
         end
         pending: begin
            // started transaction always runs to completion
            if (hs) begin
               state_nxt = almful ? blocked : idle;
            end
         end
         blocked: begin
            if (!almful) begin
               state_nxt = idle;
            end
         end
         default: state_nxt = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= idle;
         logb_valid <= 1'b0;
         loge_valid <= 1'b0;
      end else begin
         state <= state_nxt;
         logb_valid <= begin_seen;
         loge_valid <= hs;
      end
   end

   // payload as seen on the begin cycle
   always_ff @(posedge clk) begin
      if (begin_seen) begin
         logb_data <= src_data;
      end
   end

endmodule

`default_nettype wire

//--- rr_logb_packer.sv
`timescale 1ns/1ps
`default_nettype none

// squeezes the begin payloads of all channels into one word
module rr_logb_packer import rr_pkg::*; #(
   parameter int ch_cnt = 3
) (
   input wire logic clk,
   input wire logic rstn,
   input wire ch_mask_t logb_valid,
   input wire ch_data_t logb_data [max_ch],
   output plogb_t plogb,
   output ch_mask_t logb_valid_q
);

   logic [plogb_data_w-1:0] packed_data;
   len_t packed_len;
   logic any_valid;

   logic [plogb_data_w-1:0] data_q;
   len_t len_q;
   logic any_q;

   // valid payloads land side by side from bit 0, lowest channel first
   always_comb begin
      int unsigned n;
      n = 0;
      packed_data = '0;
      for (int i = 0; i < ch_cnt; i++) begin
         if (logb_valid[i]) begin
            packed_data[n*ch_data_w +: ch_data_w] = logb_data[i];
            n++;
         end
      end
      // 8 bits per begin
      packed_len = len_t'(n * ch_data_w);
   end

   assign any_valid = |logb_valid[ch_cnt-1:0];

   // control half of the stage
   always_ff @(posedge clk) begin
      if (!rstn) begin
         any_q <= 1'b0;
         logb_valid_q <= '0;
      end else begin
         any_q <= any_valid;
         // begin mask travels with its payload
         logb_valid_q <= logb_valid;
      end
   end

   // payload half, only meaningful while any_q is high
   always_ff @(posedge clk) begin
      data_q <= packed_data;
      len_q <= packed_len;
   end

   assign plogb = '{any_valid: any_q, data: data_q, len: len_q};

endmodule

`default_nettype wire

//--- rr_packed2writeback_bus.sv
`timescale 1ns/1ps
`default_nettype none

// turns packed begins plus end pulses into records on a valid/ready stream
module rr_packed2writeback_bus import rr_pkg::*; #(
   parameter int ch_cnt = 3,
   parameter int fifo_ptr_width = 4,
   parameter int almful_threshold = 6
) (
   input wire logic clk,
   input wire logic rstn,
   input wire plogb_t plogb,
   input wire ch_mask_t logb_valid,
   input wire ch_mask_t loge_valid,
   output logic logb_almful,
   output record_t out_rec,
   output logic out_valid,
   input wire logic out_ready
);

   // almful once only almful_threshold entries are left
   localparam int watermark = 2 ** fifo_ptr_width - almful_threshold;
   localparam ch_mask_t ch_used = ch_mask_t'((1 << ch_cnt) - 1);

   if (almful_threshold >= 2 ** fifo_ptr_width) begin : g_cfg_check
      $error("almful_threshold %0d does not fit a fifo of %0d entries",
         almful_threshold, 2 ** fifo_ptr_width);
   end

   // ends delayed by one so they line up with the packer stage
   ch_mask_t loge_q;
   // ends finished since the last record, at most one per channel
   ch_mask_t loge_acc;
   record_t push_rec;
   logic push;
   logic fifo_wmark;
   logic fifo_oflow;

   assign push = plogb.any_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         loge_q <= '0;
         loge_acc <= '0;
      end else begin
         loge_q <= loge_valid & ch_used;
         // record takes the mask, same-cycle ends start the next one
         if (push) begin
            loge_acc <= loge_q;
         end else begin
            loge_acc <= loge_acc | loge_q;
         end
      end
   end

   // payload, end mask, begin mask, packed from the lsb up
   assign push_rec.data = rec_data_w'({plogb.data, loge_acc[ch_cnt-1:0],
                                       logb_valid[ch_cnt-1:0]});
   assign push_rec.len = plogb.len + len_t'(2 * ch_cnt);

   ram_fifo_ft #(
      .width($bits(record_t)),
      .ptr_width(fifo_ptr_width),
      .watermark(watermark)
   ) u_logb_fifo (
      .clk(clk),
      .rstn(rstn),
      .push(push),
      .push_data(push_rec),
      .pop(out_valid && out_ready),
      .pop_data(out_rec),
      .valid(out_valid),
      .wmark(fifo_wmark),
      .oflow(fifo_oflow),
      .empty()
   );

   // one register, loggers see it a cycle late
   always_ff @(posedge clk) begin
      if (!rstn) begin
         logb_almful <= 1'b0;
      end else begin
         logb_almful <= fifo_wmark;
      end
   end

endmodule

`default_nettype wire

//--- rr_pkg.sv
`default_nettype none

// shared widths, types and bus structs for the record-side logger
package rr_pkg;

   // payload bits carried by one channel
   localparam int ch_data_w = 8;
   // most channels a recorder can watch, sizes every struct field
   localparam int max_ch = 4;
   // packed payload area of one record
   localparam int plogb_data_w = max_ch * ch_data_w;
   // record data: payload, end mask, begin mask
   localparam int rec_data_w = plogb_data_w + 2 * max_ch;

   typedef logic [ch_data_w-1:0] ch_data_t;
   // one bit per channel, bit i belongs to channel i
   typedef logic [max_ch-1:0] ch_mask_t;
   // record length in bits, 40 at most
   typedef logic [7:0] len_t;

   // packer output, payloads packed toward the lsb
   typedef struct packed {
      logic any_valid;
      logic [plogb_data_w-1:0] data;
      len_t len;
   } plogb_t;

   // one trace record
   // data msb to lsb: payload, end mask, begin mask (each mask ch_cnt bits wide)
   // len counts payload bits plus both masks
   typedef struct packed {
      logic [rec_data_w-1:0] data;
      len_t len;
   } record_t;

   // logger fsm
   typedef enum logic [1:0] {
      idle,
      pending,
      blocked
   } logger_state_t;

endpackage

`default_nettype wire

//--- rr_record_properties.sv
`timescale 1ns/1ps
`default_nettype none

// checks on the writeback block, bound in from outside
module rr_record_properties import rr_pkg::*; (
   input wire logic clk,
   input wire logic rstn,
   input wire logic push,
   input wire ch_mask_t loge_q,
   input wire ch_mask_t loge_acc,
   input wire logic oflow,
   input wire logic almful,
   input wire record_t out_rec,
   input wire logic out_valid,
   input wire logic out_ready
);

   int fail_cnt = 0;

   // threshold covers the pipeline, fifo never drops a record
   a_no_oflow: assert property (@(posedge clk) disable iff (!rstn) !oflow)
      else begin
         fail_cnt++;
         $error("fifo overflow");
      end

   // a channel ends at most once per record
   a_end_once: assert property (@(posedge clk) disable iff (!rstn)
      !push |-> ((loge_acc & loge_q) == '0))
      else begin
         fail_cnt++;
         $error("end bit accumulated twice");
      end

   a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_rec)))
      else begin
         fail_cnt++;
         $error("out_rec changed while stalled");
      end

   // begins in the first almful cycle still land two cycles later
   a_no_late_push: assert property (@(posedge clk) disable iff (!rstn)
      almful [*4] |-> !push)
      else begin
         fail_cnt++;
         $error("push long after almful");
      end

endmodule

bind rr_packed2writeback_bus rr_record_properties u_props (
   .clk(clk),
   .rstn(rstn),
   .push(push),
   .loge_q(loge_q),
   .loge_acc(loge_acc),
   .oflow(fifo_oflow),
   .almful(logb_almful),
   .out_rec(out_rec),
   .out_valid(out_valid),
   .out_ready(out_ready)
);

`default_nettype wire

//--- rr_record_top.sv
`timescale 1ns/1ps
`default_nettype none

// record side: loggers, packer, writeback
module rr_record_top import rr_pkg::*; #(
   parameter int ch_cnt = 3,
   parameter int fifo_ptr_width = 4,
   parameter int almful_threshold = 6
) (
   input wire logic clk,
   input wire logic rstn,
   input wire logic [ch_cnt-1:0] src_valid,
   input wire ch_data_t src_data [ch_cnt],
   output logic [ch_cnt-1:0] src_ready,
   output logic [ch_cnt-1:0] sink_valid,
   input wire logic [ch_cnt-1:0] sink_ready,
   output record_t out_rec,
   output logic out_valid,
   input wire logic out_ready
);

   if (ch_cnt > max_ch) begin : g_cfg_check
      $error("ch_cnt %0d exceeds max_ch %0d", ch_cnt, max_ch);
   end

   ch_mask_t logb_valid;
   ch_mask_t loge_valid;
   ch_mask_t logb_valid_q;
   ch_data_t logb_data [max_ch];
   plogb_t plogb;
   logic logb_almful;

   // one logger per used channel, spare slots tied off
   for (genvar i = 0; i < max_ch; i++) begin : g_ch
      if (i < ch_cnt) begin : g_log
         rr_channel_logger u_logger (
            .clk(clk),
            .rstn(rstn),
            .src_valid(src_valid[i]),
            .src_data(src_data[i]),
            .src_ready(src_ready[i]),
            .sink_valid(sink_valid[i]),
            .sink_ready(sink_ready[i]),
            .almful(logb_almful),
            .logb_valid(logb_valid[i]),
            .logb_data(logb_data[i]),
            .loge_valid(loge_valid[i])
         );
      end else begin : g_spare
         assign logb_valid[i] = 1'b0;
         assign loge_valid[i] = 1'b0;
         assign logb_data[i] = '0;
      end
   end

   rr_logb_packer #(
      .ch_cnt(ch_cnt)
   ) u_packer (
      .clk(clk),
      .rstn(rstn),
      .logb_valid(logb_valid),
      .logb_data(logb_data),
      .plogb(plogb),
      .logb_valid_q(logb_valid_q)
   );

   rr_packed2writeback_bus #(
      .ch_cnt(ch_cnt),
      .fifo_ptr_width(fifo_ptr_width),
      .almful_threshold(almful_threshold)
   ) u_writeback (
      .clk(clk),
      .rstn(rstn),
      .plogb(plogb),
      .logb_valid(logb_valid_q),
      .loge_valid(loge_valid),
      .logb_almful(logb_almful),
      .out_rec(out_rec),
      .out_valid(out_valid),
      .out_ready(out_ready)
   );

endmodule

`default_nettype wire

//--- tb_rr_record.sv
`timescale 1ns/1ps
`default_nettype none

// table-driven testbench for the record side with a reference model on the channel ports
module tb_rr_record import rr_pkg::*; ();

   localparam int ch_cnt = 3;
   localparam int period = 40;
   localparam int n_rows = 17;
   localparam int fifo_ptr_w = 4;
   localparam int almful_thr = 6;
   // blocking needs the watermark two cycles back and at most two pops since
   localparam int block_min = 2 ** fifo_ptr_w - almful_thr - 2;

   // row fields are test id, src_valid, sink_ready, random sink, out_ready, random out, cycles
   typedef struct packed {
      logic [2:0] test_id;
      logic [2:0] src_valid;
      logic [2:0] sink_ready;
      logic rnd_sink;
      logic out_ready;
      logic rnd_out;
      logic [7:0] reps;
   } row_t;

   row_t rows [n_rows] = '{
      // single transaction whose end rides in the following record
      {3'd1, 3'b001, 3'b111, 1'b0, 1'b1, 1'b0, 8'd1},
      {3'd1, 3'b000, 3'b111, 1'b0, 1'b1, 1'b0, 8'd6},
      {3'd1, 3'b010, 3'b111, 1'b0, 1'b1, 1'b0, 8'd1},
      {3'd1, 3'b000, 3'b111, 1'b0, 1'b1, 1'b0, 8'd8},
      // several begins in one cycle
      {3'd2, 3'b111, 3'b111, 1'b0, 1'b1, 1'b0, 8'd1},
      {3'd2, 3'b101, 3'b111, 1'b0, 1'b1, 1'b0, 8'd1},
      {3'd2, 3'b110, 3'b111, 1'b0, 1'b1, 1'b0, 8'd1},
      {3'd2, 3'b000, 3'b111, 1'b0, 1'b1, 1'b0, 8'd8},
      // late sinks make ends arrive alone
      {3'd3, 3'b011, 3'b000, 1'b0, 1'b1, 1'b0, 8'd3},
      {3'd3, 3'b000, 3'b001, 1'b0, 1'b1, 1'b0, 8'd2},
      {3'd3, 3'b000, 3'b011, 1'b0, 1'b1, 1'b0, 8'd2},
      {3'd3, 3'b100, 3'b111, 1'b0, 1'b1, 1'b0, 8'd1},
      {3'd3, 3'b000, 3'b111, 1'b0, 1'b1, 1'b0, 8'd8},
      // random ready on both sides
      {3'd4, 3'b111, 3'b000, 1'b1, 1'b0, 1'b1, 8'd40},
      {3'd4, 3'b000, 3'b111, 1'b0, 1'b1, 1'b0, 8'd24},
      // long stall up to the watermark and then a drain
      {3'd5, 3'b111, 3'b111, 1'b0, 1'b0, 1'b0, 8'd30},
      {3'd5, 3'b000, 3'b111, 1'b0, 1'b1, 1'b0, 8'd40}
   };

   string test_names [5] = '{"single channel", "multi begin", "standalone ends",
                             "output stalls", "watermark block"};

   logic clk;
   logic rstn;
   logic [ch_cnt-1:0] src_valid;
   ch_data_t src_data [ch_cnt];
   logic [ch_cnt-1:0] src_ready;
   logic [ch_cnt-1:0] sink_valid;
   logic [ch_cnt-1:0] sink_ready;
   record_t out_rec;
   logic out_valid;
   logic out_ready;

   logic [15:0] lfsr = 16'd39;
   // model state for pending transactions, accumulated ends and held sources
   logic [ch_cnt-1:0] pend = '0;
   logic [ch_cnt-1:0] acc = '0;
   logic [ch_cnt-1:0] hold = '0;
   record_t exp_q [$];
   record_t prev_rec;
   logic stall_prev = 1'b0;
   int err_cnt = 0;
   int err_base = 0;
   int rec_cnt = 0;
   int total_rec = 0;
   int blocked_cnt = 0;

   rr_record_top #(
      .ch_cnt(ch_cnt),
      .fifo_ptr_width(fifo_ptr_w),
      .almful_threshold(almful_thr)
   ) uut (
      .clk(clk),
      .rstn(rstn),
      .src_valid(src_valid),
      .src_data(src_data),
      .src_ready(src_ready),
      .sink_valid(sink_valid),
      .sink_ready(sink_ready),
      .out_rec(out_rec),
      .out_valid(out_valid),
      .out_ready(out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // galois lfsr stepped once per bit taken
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
         v = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   // inputs change 2 ns after the edge
   task automatic drive(input row_t r);
      @(posedge clk);
      #2;
      for (int i = 0; i < ch_cnt; i++) begin
         // a started transaction keeps valid and payload until taken
         if (!hold[i]) begin
            src_valid[i] = r.src_valid[i];
            if (r.src_valid[i]) begin
               src_data[i] = rand_bits(8);
            end
         end
         sink_ready[i] = r.rnd_sink ? 1'(rand_bits(1)) : r.sink_ready[i];
      end
      out_ready = r.rnd_out ? 1'(rand_bits(1)) : r.out_ready;
   endtask

   // negedge view equals what the next rising edge sees
   task automatic sample();
      logic [ch_cnt-1:0] b;
      logic [ch_cnt-1:0] e;
      logic [ch_cnt-1:0] may_block;
      logic [ch_cnt-1:0] sv_exp;
      logic [31:0] pay;
      record_t exp;
      int n;
      @(negedge clk);
      b = sink_valid & ~pend;
      e = sink_valid & sink_ready;
      // only idle channels may be hidden and only with the fifo near its watermark
      may_block = (exp_q.size() >= block_min) ? (src_valid & ~pend) : '0;
      sv_exp = (src_valid & ~may_block) | (sink_valid & may_block);
      if (sink_valid != sv_exp) begin
         $display("[FAIL] %0t sink_valid expected %b got %b", $time, sv_exp, sink_valid);
         err_cnt++;
      end
      if ((src_valid & src_ready) != e) begin
         $display("[FAIL] %0t src_ready handshake expected %b got %b",
            $time, e, src_valid & src_ready);
         err_cnt++;
      end
      blocked_cnt += $countones(src_valid & ~sink_valid);
      // begins close a record and ends of the same cycle go to the next one
      if (b != '0) begin
         pay = '0;
         n = 0;
         for (int i = 0; i < ch_cnt; i++) begin
            if (b[i]) begin
               pay[n*8 +: 8] = src_data[i];
               n++;
            end
         end
         exp.data = (rec_data_w'(pay) << (2 * ch_cnt)) | (rec_data_w'(acc) << ch_cnt)
                    | rec_data_w'(b);
         exp.len = len_t'(8 * n + 2 * ch_cnt);
         exp_q.push_back(exp);
         acc = e;
      end else begin
         acc = acc | e;
      end
      pend = (pend | b) & ~e;
      hold = src_valid & ~src_ready;
      if (stall_prev && (!out_valid || out_rec != prev_rec)) begin
         $display("[FAIL] %0t out_rec expected %h got %h while stalled",
            $time, prev_rec, out_rec);
         err_cnt++;
      end
      stall_prev = out_valid && !out_ready;
      prev_rec = out_rec;
      if (out_valid && out_ready) begin
         rec_cnt++;
         if (exp_q.size() == 0) begin
            $display("record %h came out with none expected at %0t", out_rec, $time);
            err_cnt++;
         end else begin
            exp = exp_q.pop_front();
            if (out_rec.data != exp.data) begin
               $display("[FAIL] %0t out_rec.data expected %h got %h", $time, exp.data,
                  out_rec.data);
               err_cnt++;
            end
            if (out_rec.len != exp.len) begin
               $display("[FAIL] %0t out_rec.len expected %0d got %0d", $time, exp.len,
                  out_rec.len);
               err_cnt++;
            end
         end
      end
   endtask

   task automatic finish_test(input int id);
      if (exp_q.size() != 0) begin
         $display("test %0d: %0d expected records never arrived", id, exp_q.size());
         err_cnt++;
         exp_q.delete();
      end
      if (id == 5 && blocked_cnt == 0) begin
         $display("test 5: no transaction was held back while the fifo was full");
         err_cnt++;
      end
      $display("test %0d %s: %0d records, %0d errors", id, test_names[id-1], rec_cnt,
         err_cnt - err_base);
      total_rec += rec_cnt;
      rec_cnt = 0;
      blocked_cnt = 0;
      err_base = err_cnt;
   endtask

   initial begin
      rstn = 1'b0;
      src_valid = '0;
      sink_ready = '0;
      out_ready = 1'b0;
      for (int i = 0; i < ch_cnt; i++) begin
         src_data[i] = '0;
      end
      repeat (16) @(posedge clk);
      #2;
      rstn = 1'b1;
      for (int k = 0; k < n_rows; k++) begin
         for (int c = 0; c < rows[k].reps; c++) begin
            drive(rows[k]);
            sample();
         end
         if (k == n_rows - 1 || rows[k+1].test_id != rows[k].test_id) begin
            finish_test(rows[k].test_id);
         end
      end
      if (uut.u_writeback.u_props.fail_cnt != 0) begin
         $display("%0d assertion failures in the writeback block",
            uut.u_writeback.u_props.fail_cnt);
         err_cnt += uut.u_writeback.u_props.fail_cnt;
      end
      $display("tests 5, records %0d, errors %0d", total_rec, err_cnt);
      if (err_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // run length from the table plus reset and a margin
   initial begin
      int total;
      total = 16;
      for (int k = 0; k < n_rows; k++) begin
         total += rows[k].reps;
      end
      #((total + 200) * period);
      $display("watchdog expired after %0d cycles, the run hung", total + 200);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire
